/* hw/iwm_pkg.sv */
// ============================================================
// Shared definitions for the IWM read path
// Window sizes, async clear length and register constants
// Byte and window types, decoder state encoding
// ============================================================

`default_nettype none

package iwm_pkg;

    typedef logic [7:0] byte_t;     // Disk byte or register value
    typedef logic [5:0] window_t;   // Window countdown value

    // Read decoder states
    typedef enum logic [1:0] {
        idle   = 2'd0,              // Decoder disabled
        edge_0 = 2'd1,              // Waiting for a flux transition
        edge_1 = 2'd2               // Flux seen, waiting half a window
    } decoder_state_t;

    // Bit cell windows in 14M clocks
    localparam window_t WINDOW_SLOW = 6'd56;    // 5.25 inch, 4 us cell
    localparam window_t WINDOW_FAST = 6'd28;    // 3.5 inch or fast mode, 2 us cell
    localparam window_t HALF_SLOW   = 6'd28;
    localparam window_t HALF_FAST   = 6'd14;

    // Async mode clears the data register this many clocks after a valid read
    localparam window_t ASYNC_CLEAR_CYCLES = 6'd50;

    localparam byte_t HANDSHAKE_VALUE = 8'h80;  // Read side handshake is always ready
    localparam byte_t IDLE_BUS_VALUE  = 8'hFF;

    // Switch addresses, upper three bits of the 4-bit offset
    localparam logic [2:0] SW_Q6_ADDR = 3'b110;
    localparam logic [2:0] SW_Q7_ADDR = 3'b111;

    // Mode register layout
    localparam int MODE_ASYNC_BIT   = 1;        // 1 = async handshake
    localparam int MODE_FAST_BIT    = 3;        // 1 = fast bit cells
    localparam int MODE_STATUS_BITS = 5;        // Low mode bits mirrored in status

endpackage

`default_nettype wire

/* hw/iwm_window_decoder.sv */
// ============================================================
// Flux window decoder
// Flux edge detect, window countdown and decoder FSM
// Read shift register with byte complete flag
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module iwm_window_decoder (
    input  wire               CLK_14M,
    input  wire               RESET,
    input  wire               flux_transition,  // High while a flux reversal is seen
    input  wire               motor_spinning,   // Spindle physically turning
    input  wire               disk_ready,       // Track data valid
    input  wire               is_35_inch,       // 1 = 3.5 inch drive
    input  wire               fast_mode,        // Mode register fast bit
    output iwm_pkg::byte_t    shift_reg,        // Read shift register
    output logic              byte_done         // Top bit set, one cycle
);

    // ============================================================
    // Window selection and flux edge
    // ============================================================

    logic                      enable;
    logic                      prev_flux;
    logic                      flux_edge;
    logic                      flux_pending;    // Flux arrived during edge_1
    iwm_pkg::window_t          full_window;
    iwm_pkg::window_t          half_window;
    iwm_pkg::window_t          window_counter;
    iwm_pkg::decoder_state_t   state;

    assign enable    = motor_spinning && disk_ready;
    assign flux_edge = flux_transition && !prev_flux;   // Rising edge only

    // Short cells on 3.5 inch drives and in fast mode
    assign full_window = (is_35_inch || fast_mode) ? iwm_pkg::WINDOW_FAST
                                                   : iwm_pkg::WINDOW_SLOW;
    assign half_window = (is_35_inch || fast_mode) ? iwm_pkg::HALF_FAST
                                                   : iwm_pkg::HALF_SLOW;

    // A byte is complete once a 1 has reached the top bit
    assign byte_done = shift_reg[7] && enable;

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            prev_flux <= 1'b0;
        end else begin
            prev_flux <= flux_transition;
        end
    end

    // ============================================================
    // Decoder FSM and shift register
    // ============================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            state          <= iwm_pkg::idle;
            window_counter <= '0;
            flux_pending   <= 1'b0;
            shift_reg      <= '0;
        end else if (!enable) begin
            // Spindle stopped or no track, park the decoder
            state          <= iwm_pkg::idle;
            window_counter <= '0;
            flux_pending   <= 1'b0;
        end else begin
            case (state)
                iwm_pkg::idle: begin
                    state          <= iwm_pkg::edge_0;
                    window_counter <= full_window;      // Start the first cell
                    shift_reg      <= '0;
                end

                iwm_pkg::edge_0: begin
                    if (flux_edge || flux_pending) begin
                        // Flux in this cell, sample it at half window
                        state          <= iwm_pkg::edge_1;
                        window_counter <= half_window;
                        flux_pending   <= 1'b0;
                    end else if (window_counter == 6'd1) begin
                        shift_reg      <= {shift_reg[6:0], 1'b0};  // Empty cell
                        window_counter <= full_window;
                    end else begin
                        window_counter <= window_counter - 1'b1;
                    end
                end

                iwm_pkg::edge_1: begin
                    // Next cell's flux can land early, hold it for edge_0
                    if (flux_edge) begin
                        flux_pending <= 1'b1;
                    end

                    if (window_counter == 6'd1) begin
                        shift_reg      <= {shift_reg[6:0], 1'b1};
                        state          <= iwm_pkg::edge_0;
                        window_counter <= full_window;
                    end else begin
                        window_counter <= window_counter - 1'b1;
                    end
                end

                default: begin
                    state <= iwm_pkg::idle;
                end
            endcase

            // Completed byte leaves the shift register this cycle
            if (shift_reg[7]) begin
                shift_reg <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/iwm_data_latch.sv */
// ============================================================
// Data register of the IWM read path
// Completing byte bypass, async clear countdown
// Data clear on motor start from a stopped spindle
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module iwm_data_latch (
    input  wire               CLK_14M,
    input  wire               RESET,
    input  wire               motor_active,     // Motor command on
    input  wire               motor_spinning,   // Spindle physically turning
    input  wire               async_mode,       // Mode register async bit
    input  iwm_pkg::byte_t    shift_reg,        // From the window decoder
    input  wire               byte_done,        // shift_reg holds a complete byte
    input  wire               data_read_pulse,  // One-shot CPU data read
    input  wire               data_selected,    // CPU read of data register in progress
    output iwm_pkg::byte_t    data_byte         // Data register as seen by the CPU
);

    iwm_pkg::byte_t           data_reg;
    iwm_pkg::window_t         async_count;      // 0 = no clear pending
    logic                     motor_was_on;
    logic                     motor_start;
    logic                     valid_read;
    logic                     valid_selected;

    // ============================================================
    // Bypass and read qualification
    // ============================================================

    // Same cycle read of a completing byte sees the new value
    assign data_byte = byte_done ? shift_reg : data_reg;

    // Command rises while the disk is not yet turning
    assign motor_start = motor_active && !motor_was_on && !motor_spinning;

    // A read that arms the async clear
    assign valid_read     = data_read_pulse && motor_active && async_mode && data_byte[7];
    assign valid_selected = data_selected && motor_active && async_mode && data_byte[7];

    // ============================================================
    // Data register and async countdown
    // ============================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            data_reg     <= '0;
            async_count  <= '0;
            motor_was_on <= 1'b0;
        end else begin
            motor_was_on <= motor_active;

            if (motor_start) begin
                data_reg <= '0;                 // Fresh spin up shows no byte
            end

            // Countdown, the clear lands on the last step
            if (async_count != '0) begin
                if (async_count == 6'd1 && async_mode) begin
                    data_reg <= '0;
                end
                async_count <= async_count - 1'b1;
            end

            // Rearm only when idle or when a new byte replaces the old one
            if (valid_read && (async_count == '0 || byte_done)) begin
                async_count <= iwm_pkg::ASYNC_CLEAR_CYCLES;
            end

            if (byte_done) begin
                data_reg <= shift_reg;
                if (!valid_selected) begin
                    async_count <= '0;          // Old countdown belongs to the old byte
                end
            end

            // No spindle, nothing left to clear
            if (!motor_spinning) begin
                async_count <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/iwm_reg_read.sv */
// ============================================================
// IWM register read select
// Effective Q6/Q7 decode and one-shot data read strobe
// Data, status and handshake register mux
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module iwm_reg_read (
    input  wire               CLK_14M,
    input  wire               RESET,
    input  wire               cen,              // Bus phase enable
    input  wire               rd,               // CPU read strobe
    input  wire               sw_q6,            // Latched Q6 switch
    input  wire               sw_q7,            // Latched Q7 switch
    input  wire               motor_active,
    input  wire               disk_mounted,
    input  wire               sense_bit,        // Sense line of the selected drive
    input  wire [3:0]         addr,             // Switch offset of this access
    input  iwm_pkg::byte_t    sw_mode,          // Mode register
    input  iwm_pkg::byte_t    data_byte,        // From the data latch
    output iwm_pkg::byte_t    data_out,
    output logic              data_read_pulse,
    output logic              data_selected
);

    logic                     eff_q6;
    logic                     eff_q7;
    logic                     data_reg_sel;
    logic                     rd_latched;       // Current rd already taken
    iwm_pkg::byte_t           status_reg;

    // Touching the Q6 or Q7 switch takes its new value from addr bit 0
    assign eff_q6 = (addr[3:1] == iwm_pkg::SW_Q6_ADDR) ? addr[0] : sw_q6;
    assign eff_q7 = (addr[3:1] == iwm_pkg::SW_Q7_ADDR) ? addr[0] : sw_q7;

    assign data_reg_sel    = !eff_q7 && !eff_q6;
    assign data_selected   = rd && data_reg_sel;
    assign data_read_pulse = rd && cen && !rd_latched && data_reg_sel;

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            rd_latched <= 1'b0;
        end else if (!rd) begin
            rd_latched <= 1'b0;             // Strobe released
        end else if (cen) begin
            rd_latched <= 1'b1;
        end
    end

    // Sense, reserved, motor with disk, low mode bits
    assign status_reg = {sense_bit, 1'b0, motor_active && disk_mounted,
                         sw_mode[iwm_pkg::MODE_STATUS_BITS-1:0]};

    always_comb begin
        case ({eff_q7, eff_q6})
            2'b00:   data_out = motor_active ? data_byte : iwm_pkg::IDLE_BUS_VALUE;
            2'b01:   data_out = status_reg;
            2'b10:   data_out = iwm_pkg::HANDSHAKE_VALUE;
            default: data_out = iwm_pkg::IDLE_BUS_VALUE;
        endcase
    end

endmodule

`default_nettype wire

/* hw/iwm_flux_top.sv */
// ============================================================
// IWM read path top level
// Window decoder feeding the data latch and register select
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module iwm_flux_top (
    input  wire               CLK_14M,
    input  wire               RESET,
    input  wire               cen,
    input  wire               rd,
    input  wire               flux_transition,
    input  wire               motor_active,     // Motor command
    input  wire               motor_spinning,   // Physical spindle state
    input  wire               disk_ready,
    input  wire               disk_mounted,
    input  wire               is_35_inch,
    input  wire               sense_bit,
    input  wire               sw_q6,
    input  wire               sw_q7,
    input  wire [3:0]         addr,
    input  iwm_pkg::byte_t    sw_mode,
    output iwm_pkg::byte_t    data_out
);

    iwm_pkg::byte_t           shift_reg;
    iwm_pkg::byte_t           data_byte;
    logic                     byte_done;
    logic                     data_read_pulse;
    logic                     data_selected;

    iwm_window_decoder u_decoder (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .flux_transition (flux_transition),
        .motor_spinning  (motor_spinning),
        .disk_ready      (disk_ready),
        .is_35_inch      (is_35_inch),
        .fast_mode       (sw_mode[iwm_pkg::MODE_FAST_BIT]),
        .shift_reg       (shift_reg),
        .byte_done       (byte_done)
    );

    iwm_data_latch u_latch (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .motor_active    (motor_active),
        .motor_spinning  (motor_spinning),
        .async_mode      (sw_mode[iwm_pkg::MODE_ASYNC_BIT]),
        .shift_reg       (shift_reg),
        .byte_done       (byte_done),
        .data_read_pulse (data_read_pulse),
        .data_selected   (data_selected),
        .data_byte       (data_byte)
    );

    iwm_reg_read u_reg_read (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .cen             (cen),
        .rd              (rd),
        .sw_q6           (sw_q6),
        .sw_q7           (sw_q7),
        .motor_active    (motor_active),
        .disk_mounted    (disk_mounted),
        .sense_bit       (sense_bit),
        .addr            (addr),
        .sw_mode         (sw_mode),
        .data_byte       (data_byte),
        .data_out        (data_out),
        .data_read_pulse (data_read_pulse),
        .data_selected   (data_selected)
    );

endmodule

`default_nettype wire

/* testbench/tb_iwm_model.svh */
// ============================================================
// Reference model and drivers for the IWM read testbench
// Window and register rules, seeded disk byte source
// Flux cell driver and CPU register read
// ============================================================

`ifndef TB_IWM_MODEL_SVH
`define TB_IWM_MODEL_SVH

// Bit cell length in clocks, short cells on 3.5 inch or in fast mode
function automatic int full_window(input logic is_35, input logic fast);
    full_window = (is_35 || fast) ? 28 : 56;
endfunction

// Sense, reserved 0, motor with disk, low five mode bits
function automatic logic [7:0] expect_status(input logic sense, input logic mounted,
                                             input logic motor, input logic [7:0] mode);
    expect_status = {sense, 1'b0, motor & mounted, mode[4:0]};
endfunction

// Register seen for an effective Q7/Q6 pair
function automatic logic [7:0] expect_read(input logic q7, input logic q6, input logic motor,
                                           input logic [7:0] data, input logic [7:0] status);
    case ({q7, q6})
        2'b00:   expect_read = motor ? data : 8'hFF;  // Data bus floats high, motor off
        2'b01:   expect_read = status;
        2'b10:   expect_read = 8'h80;                 // Handshake always ready
        default: expect_read = 8'hFF;
    endcase
endfunction

// At most two empty cells in a row
function automatic logic zero_runs_ok(input logic [7:0] b);
    int run;
    run = 0;
    zero_runs_ok = 1'b1;
    for (int i = 6; i >= 0; i--) begin
        run = b[i] ? 0 : run + 1;
        if (run > 2) zero_runs_ok = 1'b0;
    end
endfunction

// Random disk byte, top bit set and unlike the previous one
task automatic pick_disk_byte(input iwm_pkg::byte_t prev, output iwm_pkg::byte_t b);
    int rnd;
    b = prev;
    while (b == prev || !zero_runs_ok(b)) begin
        rnd = $random(seed);
        b   = {1'b1, rnd[6:0]};
    end
endtask

// One cell per bit, a 1 is a one clock flux pulse at the start of its cell
task automatic send_byte(input iwm_pkg::byte_t b, input int win);
    for (int i = 7; i >= 0; i--) begin
        @(posedge CLK_14M);
        flux_transition <= b[i];
        @(posedge CLK_14M);
        flux_transition <= 1'b0;
        repeat (win - 2) @(posedge CLK_14M);
    end
    model_data = b;                          // Unread byte is simply overwritten
endtask

// Register read, route 1 overrides Q6 through addr, route 2 overrides Q7
task automatic cpu_read(input logic q7, input logic q6, input int route,
                        output iwm_pkg::byte_t value);
    @(posedge CLK_14M);
    sw_q7 <= q7;
    sw_q6 <= q6;
    addr  <= 4'h0;
    if (route == 1) begin
        sw_q6 <= !q6;                        // Latched switch disagrees with addr
        addr  <= {3'b110, q6};
    end
    if (route == 2) begin
        sw_q7 <= !q7;
        addr  <= {3'b111, q7};
    end
    rd  <= 1'b1;
    cen <= 1'b1;
    @(negedge CLK_14M);
    value = data_out;                        // Mid cycle, output settled
    @(posedge CLK_14M);
    rd   <= 1'b0;
    cen  <= 1'b0;
    addr <= 4'h0;
endtask

`endif

/* testbench/tb_iwm_flux.sv */
// ============================================================
// Testbench for the IWM read path
// Seeded random flux bytes checked against a reference model
// Register reads, async clear and motor start clear
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module tb_iwm_flux;

    localparam int CLK_PERIOD     = 40;
    localparam int RUN_BYTES      = 12;                  // Bytes per decoding run
    localparam int TOTAL_BYTES    = 3 * RUN_BYTES + 2;   // Three runs plus async test
    localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 8 * 56 + 4000;
    localparam int ASYNC_WAIT     = 52;                  // Countdown length plus 2

    logic             CLK_14M         = 1'b0;
    logic             RESET           = 1'b1;
    logic             cen             = 1'b0;
    logic             rd              = 1'b0;
    logic             flux_transition = 1'b0;
    logic             motor_active    = 1'b0;
    logic             motor_spinning  = 1'b0;
    logic             disk_ready      = 1'b0;
    logic             disk_mounted    = 1'b0;
    logic             is_35_inch      = 1'b0;
    logic             sense_bit       = 1'b0;
    logic             sw_q6           = 1'b0;
    logic             sw_q7           = 1'b0;
    logic [3:0]       addr            = 4'h0;
    iwm_pkg::byte_t   sw_mode         = 8'h00;
    iwm_pkg::byte_t   data_out;

    integer           seed = 10037;
    iwm_pkg::byte_t   model_data = 8'h00;               // Expected data register
    iwm_pkg::byte_t   sent[$];
    iwm_pkg::byte_t   received[$];
    iwm_pkg::byte_t   last_seen;
    logic             polling = 1'b0;
    int               checks = 0, errors = 0, tests = 0, tests_failed = 0, test_errors = 0;

    `include "tb_iwm_model.svh"

    iwm_flux_top UUT (.*);

    always #(CLK_PERIOD / 2) CLK_14M = ~CLK_14M;

    // Data register poller, keeps each new complete byte
    always @(negedge CLK_14M) begin
        if (polling && data_out != last_seen) begin
            last_seen = data_out;
            if (data_out[7]) received.push_back(data_out);
        end
    end

    // Watchdog sized from the byte counts of all tests
    initial begin
        #(CLK_PERIOD * TIMEOUT_CYCLES);
        $display("Watchdog expired, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic report_test(input string name);
        tests++;
        errors += test_errors;
        if (test_errors != 0) tests_failed++;
        $display("%s: %s, %0d errors", name, (test_errors == 0) ? "pass" : "FAIL", test_errors);
        test_errors = 0;
    endtask

    // One decoding run, the first byte may be lost while the decoder syncs
    task automatic decode_run(input logic is_35, input iwm_pkg::byte_t mode, input string name);
        iwm_pkg::byte_t b;
        int offset;
        @(posedge CLK_14M);
        is_35_inch <= is_35;
        sw_mode    <= mode;
        repeat (4) @(posedge CLK_14M);
        @(negedge CLK_14M);
        last_seen = data_out;
        b = last_seen;
        sent.delete();
        received.delete();
        polling = 1'b1;
        repeat (RUN_BYTES) begin
            pick_disk_byte(b, b);
            sent.push_back(b);
            send_byte(b, full_window(is_35, mode[3]));
        end
        repeat (8) @(posedge CLK_14M);          // Last byte lands well inside its cell
        polling = 1'b0;
        offset = sent.size() - received.size();
        if (offset < 0 || offset > 1) begin
            $display("%s: %0d bytes read back for %0d sent", name, received.size(), sent.size());
            test_errors++;
        end else begin
            for (int i = 0; i < received.size(); i++) begin
                checks++;
                if (received[i] !== sent[i + offset]) begin
                    $display("ERROR: data_out = %02h, expected %02h", received[i], sent[i + offset]);
                    test_errors++;
                end
            end
        end
        report_test(name);
    endtask

    initial begin
        iwm_pkg::byte_t got;
        iwm_pkg::byte_t exp;
        iwm_pkg::byte_t b;
        int rnd;
        logic q7, q6, motor;
        repeat (16) @(posedge CLK_14M);
        RESET          <= 1'b0;
        motor_active   <= 1'b1;
        motor_spinning <= 1'b1;
        disk_ready     <= 1'b1;
        disk_mounted   <= 1'b1;

        // ============================================================
        // Byte decoding in all three cell sizes
        // ============================================================
        decode_run(1'b0, 8'h00, "decode 5.25 inch");
        decode_run(1'b1, 8'h00, "decode 3.5 inch");
        decode_run(1'b0, 8'h08, "decode fast mode");

        // Status register under random drive state and mode
        for (int n = 0; n < 24; n++) begin
            rnd = $random(seed);
            @(posedge CLK_14M);
            sense_bit    <= rnd[0];
            disk_mounted <= rnd[1];
            motor_active <= rnd[2];
            sw_mode      <= rnd[15:8];
            cpu_read(1'b0, 1'b1, n % 3, got);
            exp = expect_read(1'b0, 1'b1, rnd[2], model_data,
                              expect_status(rnd[0], rnd[1], rnd[2], rnd[15:8]));
            checks++;
            if (got !== exp) begin
                $display("ERROR: data_out = %02h, expected %02h (status)", got, exp);
                test_errors++;
            end
        end
        report_test("status register");
        @(posedge CLK_14M);
        sw_mode      <= 8'h00;
        disk_mounted <= 1'b1;

        // Handshake, Q7=Q6=1 and motor off reads, latched and through addr
        for (int route = 0; route < 3; route++) begin
            for (int k = 0; k < 3; k++) begin
                q7    = (k != 2);
                q6    = (k == 1);
                motor = (k != 2);
                @(posedge CLK_14M);
                motor_active <= motor;
                cpu_read(q7, q6, route, got);
                exp = expect_read(q7, q6, motor, model_data, 8'h00);
                checks++;
                if (got !== exp) begin
                    $display("ERROR: data_out = %02h, expected %02h (Q7 %b Q6 %b route %0d)",
                             got, exp, q7, q6, route);
                    test_errors++;
                end
            end
        end
        report_test("handshake and idle");
        @(posedge CLK_14M);
        motor_active <= 1'b1;

        // ============================================================
        // Async clear, then the same sequence in sync mode
        // ============================================================
        for (int a = 1; a >= 0; a--) begin
            @(posedge CLK_14M);
            is_35_inch <= 1'b0;
            sw_mode    <= (a == 1) ? 8'h02 : 8'h00;
            pick_disk_byte(model_data, b);
            send_byte(b, full_window(1'b0, 1'b0));
            repeat (4) @(posedge CLK_14M);
            cpu_read(1'b0, 1'b0, 0, got);           // Valid read arms the countdown
            checks++;
            if (got !== model_data) begin
                $display("ERROR: data_out = %02h, expected %02h (first read)", got, model_data);
                test_errors++;
            end
            repeat (ASYNC_WAIT) @(posedge CLK_14M);
            if (a == 1) model_data = 8'h00;         // Only async mode clears
            cpu_read(1'b0, 1'b0, 0, got);
            checks++;
            if (got !== model_data) begin
                $display("ERROR: data_out = %02h, expected %02h (after wait)", got, model_data);
                test_errors++;
            end
        end
        report_test("async clear");

        // Motor command from a stopped spindle empties the data register
        @(posedge CLK_14M);
        motor_active   <= 1'b0;
        motor_spinning <= 1'b0;
        repeat (3) @(posedge CLK_14M);
        motor_active <= 1'b1;
        model_data = 8'h00;
        repeat (2) @(posedge CLK_14M);
        cpu_read(1'b0, 1'b0, 0, got);
        checks++;
        if (got !== model_data) begin
            $display("ERROR: data_out = %02h, expected %02h (motor start)", got, model_data);
            test_errors++;
        end
        report_test("motor start clear");

        $display("tests %0d, tests failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+testbench
hw/iwm_pkg.sv
hw/iwm_window_decoder.sv
hw/iwm_data_latch.sv
hw/iwm_reg_read.sv
hw/iwm_flux_top.sv
testbench/tb_iwm_flux.sv
